/* common/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

   // Core port widths
   localparam int REGION_WIDTH = 5;                  // One-hot request region
   localparam int PCX_WIDTH    = 124;                // Processor-to-cache packet
   localparam int CPX_WIDTH    = 145;                // Cache-to-processor packet

   // Wishbone widths
   localparam int WB_ADDR_WIDTH = 64;
   localparam int WB_DATA_WIDTH = 64;
   localparam int WB_SEL_WIDTH  = 8;                 // One bit per byte lane

   // FIFO sizing
   localparam int FIFO_DEPTH     = 4;
   localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);   // Holds 0 to FIFO_DEPTH

   // Fixed return packet contents
   localparam logic [2*WB_DATA_WIDTH-1:0] WAKEUP_DATA = 128'h10001;
   localparam logic [5:0]                 RETURN_INFO = 6'b000100;

   // Request types the bridge serves
   typedef enum logic [4:0] {
      LOAD_RQ  = 5'b00000,
      IMISS_RQ = 5'b10000,
      STORE_RQ = 5'b00001
   } pcx_rq_e;

   // Return types sent back to the core
   typedef enum logic [3:0] {
      LOAD_RET  = 4'b0000,
      IFILL_RET = 4'b0001,
      ST_ACK    = 4'b0100,
      INT_RET   = 4'b0111                            // Used for the wakeup only
   } cpx_ret_e;

   // Access sizes
   typedef enum logic [2:0] {
      SZ_1B  = 3'b000,
      SZ_2B  = 3'b001,
      SZ_4B  = 3'b010,
      SZ_8B  = 3'b011,
      SZ_16B = 3'b111                                // Needs two bus beats
   } pcx_size_e;

   // Request packet, bit 123 down to bit 0
   typedef struct packed {
      logic                     valid;
      pcx_rq_e                  rq_type;
      logic                     noncache;
      logic [2:0]               cpu_id;
      logic [1:0]               thread_id;
      logic [2:0]               buffer_id;
      logic [1:0]               way_pkt_id;          // L1 way or packet id
      pcx_size_e                size;
      logic [39:0]              addr;
      logic [WB_DATA_WIDTH-1:0] store_data;
   } pcx_packet_t;

   // Return packet, bit 144 down to bit 0
   typedef struct packed {
      logic                       valid;
      cpx_ret_e                   ret_type;
      logic [2:0]                 error;
      logic                       noncache;
      logic [1:0]                 thread_id;
      logic [5:0]                 info;              // Interrupt source etc
      logic [2*WB_DATA_WIDTH-1:0] load_data;
   } cpx_packet_t;

   // Request FIFO entry
   typedef struct packed {
      logic [REGION_WIDTH-1:0] region;
      pcx_packet_t             pkt;
   } pcx_entry_t;

endpackage

`default_nettype wire

/* common/pkt_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pkt_fifo_if #(
   parameter int DATA_WIDTH = 129
);

   logic                  push;       // Write strobe
   logic [DATA_WIDTH-1:0] push_data;
   logic                  full;
   logic                  pop;        // Read strobe, only while not empty
   logic [DATA_WIDTH-1:0] pop_data;   // Head entry, valid while not empty
   logic                  empty;

   modport writer (
      output push, push_data,
      input  full
   );

   modport buffer (
      input  push, push_data, pop,
      output full, pop_data, empty
   );

   modport reader (
      output pop,
      input  pop_data, empty
   );

endinterface

`default_nettype wire

/* logic/pkt_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo import bridge_pkg::*; #(
   parameter int DATA_WIDTH = 129
) (
   input  wire logic   sys_clock_i,
   input  wire logic   sys_reset_i,
   pkt_fifo_if.buffer  fifo
);

   logic [DATA_WIDTH-1:0]     mem [FIFO_DEPTH];  // Entry storage
   logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
   logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
   logic [FIFO_CNT_WIDTH-1:0] count;             // Entries held

   // Pointers and count
   always_ff @(posedge sys_clock_i) begin
      if (sys_reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (fifo.push) begin
            wr_ptr <= (wr_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (fifo.pop) begin
            rd_ptr <= (rd_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({fifo.push, fifo.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // Idle or simultaneous push and pop
         endcase
      end
   end

   always_ff @(posedge sys_clock_i) begin
      if (fifo.push) begin
         mem[wr_ptr] <= fifo.push_data;
      end
   end

   // Show-ahead read
   assign fifo.pop_data = mem[rd_ptr];
   assign fifo.empty    = (count == '0);
   assign fifo.full     = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));

   // The producer has no back-pressure, so depth must cover the traffic
   a_no_overflow : assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
      fifo.push |-> !fifo.full);

   a_no_underflow : assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
      fifo.pop |-> !fifo.empty);

endmodule

`default_nettype wire

/* logic/pcx_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module pcx_capture import bridge_pkg::*; (
   input  wire logic                    sys_clock_i,
   input  wire logic                    sys_reset_i,
   input  wire logic [REGION_WIDTH-1:0] spc_req_i,        // One-hot region, cycle N
   input  wire pcx_packet_t             spc_packetout_i,  // Packet, cycle N+1
   output logic [REGION_WIDTH-1:0]      spc_grant_o,
   pkt_fifo_if.writer                   req_fifo
);

   logic [REGION_WIDTH-1:0] req_dly1;   // Region of the packet now on the bus
   logic [REGION_WIDTH-1:0] req_dly2;   // Same region one cycle on, for the grant
   pcx_entry_t              entry;

   // Region delay line
   always_ff @(posedge sys_clock_i) begin
      if (sys_reset_i) begin
         req_dly1 <= '0;
         req_dly2 <= '0;
      end else begin
         req_dly1 <= spc_req_i;
         req_dly2 <= req_dly1;
      end
   end

   // Packet follows its region by one cycle, so pair it with the first stage
   always_comb begin
      entry.region = req_dly1;
      entry.pkt    = spc_packetout_i;
   end

   assign req_fifo.push      = |req_dly1;    // Any region bit marks a request
   assign req_fifo.push_data = entry;

   // Grant two cycles after the request
   assign spc_grant_o = req_dly2;

   // Core sends one-hot regions only
   a_region_onehot : assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
      (|spc_req_i) |-> $onehot(spc_req_i));

endmodule

`default_nettype wire

/* wb_master/wb_request_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_request_engine import bridge_pkg::*; (
   input  wire logic                     sys_clock_i,
   input  wire logic                     sys_reset_i,
   pkt_fifo_if.reader                    req_fifo,
   pkt_fifo_if.writer                    ret_fifo,
   input  wire logic                     wbm_ack_i,
   input  wire logic [WB_DATA_WIDTH-1:0] wbm_data_i,
   output logic                          wbm_cycle_o,
   output logic                          wbm_strobe_o,
   output logic                          wbm_we_o,
   output logic [WB_ADDR_WIDTH-1:0]      wbm_addr_o,
   output logic [WB_DATA_WIDTH-1:0]      wbm_data_o,
   output logic [WB_SEL_WIDTH-1:0]       wbm_sel_o
);

   typedef enum logic [2:0] {
      ST_WAKEUP,
      ST_IDLE,
      ST_BEGIN1,
      ST_END1,
      ST_BEGIN2,
      ST_END2,
      ST_PUSH
   } eng_state_e;

   eng_state_e                 state;
   pcx_entry_t                 head_entry;   // FIFO head
   pcx_entry_t                 req_q;        // Request being served
   logic [2*WB_DATA_WIDTH-1:0] ld_data;      // Assembled load data
   logic                       is_store;
   logic                       two_beat;
   cpx_packet_t                ret_pkt;
   cpx_packet_t                wakeup_pkt;

   // Byte lanes for a single access
   function automatic logic [WB_SEL_WIDTH-1:0] size_to_sel(input pcx_size_e size,
                                                          input logic [2:0] lsb);
      case (size)
         SZ_1B:   size_to_sel = WB_SEL_WIDTH'(8'b0000_0001) << lsb;
         SZ_2B:   size_to_sel = WB_SEL_WIDTH'(8'b0000_0011) << {lsb[2:1], 1'b0};
         SZ_4B:   size_to_sel = WB_SEL_WIDTH'(8'b0000_1111) << {lsb[2], 2'b00};
         default: size_to_sel = '1;             // 8B and 16B use all lanes
      endcase
   endfunction

   function automatic cpx_ret_e ret_type_of(input pcx_rq_e rq);
      case (rq)
         IMISS_RQ: ret_type_of = IFILL_RET;
         STORE_RQ: ret_type_of = ST_ACK;
         default:  ret_type_of = LOAD_RET;
      endcase
   endfunction

   assign head_entry = req_fifo.pop_data;
   assign is_store   = (req_q.pkt.rq_type == STORE_RQ);
   assign two_beat   = (req_q.pkt.rq_type == IMISS_RQ) ||
                       ((req_q.pkt.rq_type == LOAD_RQ) && (req_q.pkt.size == SZ_16B));

   // Main FSM and Wishbone outputs
   always_ff @(posedge sys_clock_i) begin
      if (sys_reset_i) begin
         state        <= ST_WAKEUP;
         wbm_cycle_o  <= 1'b0;
         wbm_strobe_o <= 1'b0;
         wbm_we_o     <= 1'b0;
         wbm_addr_o   <= '0;
         wbm_data_o   <= '0;
         wbm_sel_o    <= '0;
      end else begin
         // Any acked access ends here, bus idles the next cycle
         if (wbm_strobe_o && wbm_ack_i) begin
            wbm_cycle_o  <= 1'b0;
            wbm_strobe_o <= 1'b0;
            wbm_we_o     <= 1'b0;
            wbm_addr_o   <= '0;
            wbm_data_o   <= '0;
            wbm_sel_o    <= '0;
         end
         case (state)
            ST_WAKEUP: state <= ST_IDLE;       // Wakeup pushed this cycle
            ST_IDLE: begin
               if (!req_fifo.empty) state <= ST_BEGIN1;
            end
            ST_BEGIN1: begin
               wbm_cycle_o  <= 1'b1;
               wbm_strobe_o <= 1'b1;
               wbm_we_o     <= is_store;
               wbm_addr_o   <= {req_q.region, 19'b0, req_q.pkt.addr[39:3], 3'b000};
               wbm_data_o   <= is_store ? req_q.pkt.store_data : '0;
               wbm_sel_o    <= (req_q.pkt.rq_type == IMISS_RQ) ? '1 :
                               size_to_sel(req_q.pkt.size, req_q.pkt.addr[2:0]);
               state        <= ST_END1;
            end
            ST_END1: begin
               if (wbm_ack_i) state <= two_beat ? ST_BEGIN2 : ST_PUSH;
            end
            ST_BEGIN2: begin
               // Other doubleword of the same quadword
               wbm_cycle_o  <= 1'b1;
               wbm_strobe_o <= 1'b1;
               wbm_we_o     <= 1'b0;
               wbm_addr_o   <= {req_q.region, 19'b0, req_q.pkt.addr[39:4],
                                ~req_q.pkt.addr[3], 3'b000};
               wbm_data_o   <= '0;
               wbm_sel_o    <= '1;
               state        <= ST_END2;
            end
            ST_END2: begin
               if (wbm_ack_i) state <= ST_PUSH;
            end
            ST_PUSH: begin
               if (!ret_fifo.full) state <= ST_IDLE;   // Hold until there is room
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clock_i) begin
      if (req_fifo.pop) req_q <= head_entry;
   end

   // Load data, doubleword with address bit 3 clear goes high
   always_ff @(posedge sys_clock_i) begin
      if (state == ST_END1 && wbm_ack_i) begin
         if (is_store) ld_data <= '0;
         else if (!req_q.pkt.addr[3]) ld_data <= {wbm_data_i, {WB_DATA_WIDTH{1'b0}}};
         else ld_data <= {{WB_DATA_WIDTH{1'b0}}, wbm_data_i};
      end else if (state == ST_END2 && wbm_ack_i) begin
         if (req_q.pkt.addr[3]) ld_data[2*WB_DATA_WIDTH-1:WB_DATA_WIDTH] <= wbm_data_i;
         else ld_data[WB_DATA_WIDTH-1:0] <= wbm_data_i;
      end
   end

   // Return packets
   always_comb begin
      wakeup_pkt           = '0;
      wakeup_pkt.valid     = 1'b1;
      wakeup_pkt.ret_type  = INT_RET;
      wakeup_pkt.load_data = WAKEUP_DATA;

      ret_pkt           = '0;
      ret_pkt.valid     = 1'b1;
      ret_pkt.ret_type  = ret_type_of(req_q.pkt.rq_type);
      ret_pkt.noncache  = req_q.pkt.noncache;
      ret_pkt.thread_id = req_q.pkt.thread_id;
      ret_pkt.info      = RETURN_INFO;
      ret_pkt.load_data = ld_data;
   end

   assign req_fifo.pop       = (state == ST_IDLE) && !req_fifo.empty;
   assign ret_fifo.push      = (state == ST_WAKEUP) || ((state == ST_PUSH) && !ret_fifo.full);
   assign ret_fifo.push_data = (state == ST_WAKEUP) ? wakeup_pkt : ret_pkt;

   // Capture side forwards any type, only three are served
   a_rq_type : assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
      req_fifo.pop |-> head_entry.pkt.rq_type inside {LOAD_RQ, IMISS_RQ, STORE_RQ});

   a_stb_held : assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
      $fell(wbm_strobe_o) |-> $past(wbm_ack_i));

endmodule

`default_nettype wire

/* logic/cpx_return_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module cpx_return_stage import bridge_pkg::*; (
   input  wire logic  sys_clock_i,
   input  wire logic  sys_reset_i,
   pkt_fifo_if.reader ret_fifo,
   output logic       spc_ready_o,
   output cpx_packet_t spc_packetin_o
);

   typedef enum logic {
      RS_IDLE,           // Pop when something is queued
      RS_DRIVE           // Present the packet for one cycle
   } rs_state_e;

   rs_state_e   state;
   cpx_packet_t held_pkt;   // Packet popped last cycle

   always_ff @(posedge sys_clock_i) begin
      if (sys_reset_i) begin
         state <= RS_IDLE;
      end else begin
         case (state)
            RS_IDLE:  if (!ret_fifo.empty) state <= RS_DRIVE;
            RS_DRIVE: state <= RS_IDLE;           // Always back, no back-to-back ready
            default:  state <= RS_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clock_i) begin
      if (ret_fifo.pop) held_pkt <= ret_fifo.pop_data;
   end

   assign ret_fifo.pop   = (state == RS_IDLE) && !ret_fifo.empty;
   assign spc_ready_o    = (state == RS_DRIVE);
   assign spc_packetin_o = (state == RS_DRIVE) ? held_pkt : '0;   // Zero between pulses

   // Engine only queues valid packets
   a_ready_valid : assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
      spc_ready_o |-> spc_packetin_o.valid);

endmodule

`default_nettype wire

/* logic/spc2wb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module spc2wb_bridge import bridge_pkg::*; (
   input  wire logic                     sys_clock_i,
   input  wire logic                     sys_reset_i,

   // Core request port
   input  wire logic [REGION_WIDTH-1:0]  spc_req_i,
   input  wire logic [PCX_WIDTH-1:0]     spc_packetout_i,
   output logic [REGION_WIDTH-1:0]       spc_grant_o,

   // Core return port
   output logic                          spc_ready_o,
   output logic [CPX_WIDTH-1:0]          spc_packetin_o,

   // Wishbone master
   input  wire logic                     wbm_ack_i,
   input  wire logic [WB_DATA_WIDTH-1:0] wbm_data_i,
   output logic                          wbm_cycle_o,
   output logic                          wbm_strobe_o,
   output logic                          wbm_we_o,
   output logic [WB_ADDR_WIDTH-1:0]      wbm_addr_o,
   output logic [WB_DATA_WIDTH-1:0]      wbm_data_o,
   output logic [WB_SEL_WIDTH-1:0]       wbm_sel_o
);

   pkt_fifo_if #(.DATA_WIDTH(REGION_WIDTH + PCX_WIDTH)) req_fifo_if ();   // Capture to engine
   pkt_fifo_if #(.DATA_WIDTH(CPX_WIDTH))                ret_fifo_if ();   // Engine to core

   pcx_capture pcx_capture0 (
      .sys_clock_i     (sys_clock_i),
      .sys_reset_i     (sys_reset_i),
      .spc_req_i       (spc_req_i),
      .spc_packetout_i (spc_packetout_i),
      .spc_grant_o     (spc_grant_o),
      .req_fifo        (req_fifo_if.writer)
   );

   pkt_fifo #(.DATA_WIDTH(REGION_WIDTH + PCX_WIDTH)) req_fifo0 (
      .sys_clock_i (sys_clock_i),
      .sys_reset_i (sys_reset_i),
      .fifo        (req_fifo_if.buffer)
   );

   wb_request_engine wb_request_engine0 (
      .sys_clock_i  (sys_clock_i),
      .sys_reset_i  (sys_reset_i),
      .req_fifo     (req_fifo_if.reader),
      .ret_fifo     (ret_fifo_if.writer),
      .wbm_ack_i    (wbm_ack_i),
      .wbm_data_i   (wbm_data_i),
      .wbm_cycle_o  (wbm_cycle_o),
      .wbm_strobe_o (wbm_strobe_o),
      .wbm_we_o     (wbm_we_o),
      .wbm_addr_o   (wbm_addr_o),
      .wbm_data_o   (wbm_data_o),
      .wbm_sel_o    (wbm_sel_o)
   );

   pkt_fifo #(.DATA_WIDTH(CPX_WIDTH)) ret_fifo0 (
      .sys_clock_i (sys_clock_i),
      .sys_reset_i (sys_reset_i),
      .fifo        (ret_fifo_if.buffer)
   );

   cpx_return_stage cpx_return_stage0 (
      .sys_clock_i    (sys_clock_i),
      .sys_reset_i    (sys_reset_i),
      .ret_fifo       (ret_fifo_if.reader),
      .spc_ready_o    (spc_ready_o),
      .spc_packetin_o (spc_packetin_o)
   );

endmodule

`default_nettype wire

/* verif/tb_spc2wb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spc2wb_bridge import bridge_pkg::*; ();

   localparam int          NUM_REQ   = 200;
   localparam int          CYC_LIMIT = NUM_REQ * 40 + 200;
   localparam logic [31:0] SEED      = 32'h2e20612b;
   localparam logic [63:0] RD_MASK   = 64'h5a5a_c3c3_0f0f_9696;   // Slave read data pattern

   logic                     sys_clock_i = 1'b0;
   logic                     sys_reset_i;
   logic [REGION_WIDTH-1:0]  spc_req_i;
   pcx_packet_t              spc_packetout_i;
   logic [REGION_WIDTH-1:0]  spc_grant_o;
   logic                     spc_ready_o;
   logic [CPX_WIDTH-1:0]     spc_packetin_o;
   logic                     wbm_ack_i;
   logic [WB_DATA_WIDTH-1:0] wbm_data_i;
   logic                     wbm_cycle_o;
   logic                     wbm_strobe_o;
   logic                     wbm_we_o;
   logic [WB_ADDR_WIDTH-1:0] wbm_addr_o;
   logic [WB_DATA_WIDTH-1:0] wbm_data_o;
   logic [WB_SEL_WIDTH-1:0]  wbm_sel_o;

   integer                   req_seed = SEED;    // Request stream
   integer                   wb_seed  = SEED;    // Slave delay stream
   int                       cycle_cnt = 0;
   int                       issued = 0;
   int                       ret_count = 0;       // Ready pulses seen, wakeup included
   logic                     prev_ready = 1'b0;
   logic [REGION_WIDTH-1:0]  req_d1 = '0;
   logic [REGION_WIDTH-1:0]  req_d2 = '0;

   // Expected bus accesses and return packets, oldest first
   logic [WB_ADDR_WIDTH-1:0] exp_addr_q [$];
   logic [WB_SEL_WIDTH-1:0]  exp_sel_q [$];
   logic                     exp_we_q [$];
   logic [WB_DATA_WIDTH-1:0] exp_wdata_q [$];
   cpx_packet_t              exp_ret_q [$];

   // Slave state
   logic                     ack_active = 1'b0;
   logic                     in_access = 1'b0;
   int                       wait_left = 0;
   logic [WB_ADDR_WIDTH-1:0] cur_addr;
   logic [WB_SEL_WIDTH-1:0]  cur_sel;
   logic                     cur_we;
   logic [WB_DATA_WIDTH-1:0] cur_wdata;

   spc2wb_bridge dut0 (
      .sys_clock_i     (sys_clock_i),
      .sys_reset_i     (sys_reset_i),
      .spc_req_i       (spc_req_i),
      .spc_packetout_i (spc_packetout_i),
      .spc_grant_o     (spc_grant_o),
      .spc_ready_o     (spc_ready_o),
      .spc_packetin_o  (spc_packetin_o),
      .wbm_ack_i       (wbm_ack_i),
      .wbm_data_i      (wbm_data_i),
      .wbm_cycle_o     (wbm_cycle_o),
      .wbm_strobe_o    (wbm_strobe_o),
      .wbm_we_o        (wbm_we_o),
      .wbm_addr_o      (wbm_addr_o),
      .wbm_data_o      (wbm_data_o),
      .wbm_sel_o       (wbm_sel_o)
   );

   always #2 sys_clock_i = ~sys_clock_i;   // 4 ns period

   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_value(input string what, input logic [CPX_WIDTH-1:0] got,
                              input logic [CPX_WIDTH-1:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("** Error at %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
      end
   endtask

   function automatic logic [63:0] rd_data(input logic [63:0] addr);
      rd_data = addr ^ RD_MASK;
   endfunction

   // Beat with address bit 3 clear lands in the upper half
   function automatic logic [127:0] place_beat(input logic [127:0] acc,
                                               input logic [63:0] addr);
      place_beat = acc;
      if (addr[3]) place_beat[63:0] = rd_data(addr);
      else place_beat[127:64] = rd_data(addr);
   endfunction

   function automatic logic [7:0] lane_select(input pcx_size_e size, input logic [2:0] a);
      case (size)
         SZ_1B:   lane_select = 8'h01 << a;
         SZ_2B:   lane_select = 8'h03 << (a & 3'd6);   // Halfword pair
         SZ_4B:   lane_select = 8'h0f << (a & 3'd4);   // Word half
         default: lane_select = 8'hff;
      endcase
   endfunction

   function automatic pcx_size_e pick_size(input int unsigned n);
      case ($unsigned($random(req_seed)) % n)
         0:       pick_size = SZ_1B;
         1:       pick_size = SZ_2B;
         2:       pick_size = SZ_4B;
         3:       pick_size = SZ_8B;
         default: pick_size = SZ_16B;
      endcase
   endfunction

   task automatic queue_access(input logic [63:0] addr, input logic [7:0] sel,
                               input logic we, input logic [63:0] wdata);
      exp_addr_q.push_back(addr);
      exp_sel_q.push_back(sel);
      exp_we_q.push_back(we);
      exp_wdata_q.push_back(wdata);
   endtask

   // Called on a falling edge, returns two falling edges later
   task automatic send_request();
      pcx_packet_t              pkt;
      cpx_packet_t              ret;
      logic [REGION_WIDTH-1:0]  region;
      logic [WB_ADDR_WIDTH-1:0] addr1;
      int unsigned              kind;   // 0 load, 1 16B load, 2 imiss, 3 store
      logic                     two_beat;
      kind           = $unsigned($random(req_seed)) % 4;
      region         = 5'b00001 << ($unsigned($random(req_seed)) % REGION_WIDTH);
      pkt            = '0;
      pkt.valid      = 1'b1;
      pkt.noncache   = $random(req_seed);
      pkt.cpu_id     = $random(req_seed);
      pkt.thread_id  = $random(req_seed);
      pkt.buffer_id  = $random(req_seed);
      pkt.way_pkt_id = $random(req_seed);
      pkt.addr       = 40'({$random(req_seed), $random(req_seed)});
      pkt.store_data = {$random(req_seed), $random(req_seed)};
      pkt.size       = pick_size((kind == 3) ? 4 : 5);   // Stores up to 8B
      case (kind)
         0:       pkt.rq_type = LOAD_RQ;
         1: begin
            pkt.rq_type = LOAD_RQ;
            pkt.size    = SZ_16B;
         end
         2:       pkt.rq_type = IMISS_RQ;
         default: pkt.rq_type = STORE_RQ;
      endcase

      // Model of the bus side
      addr1    = {region, 19'b0, pkt.addr[39:3], 3'b000};
      two_beat = (kind == 1) || (kind == 2) || ((kind == 0) && (pkt.size == SZ_16B));
      queue_access(addr1, (kind == 2) ? 8'hff : lane_select(pkt.size, pkt.addr[2:0]),
                   kind == 3, (kind == 3) ? pkt.store_data : 64'h0);
      if (two_beat) queue_access(addr1 ^ 64'h8, 8'hff, 1'b0, 64'h0);   // Other doubleword

      // Model of the return packet
      ret           = '0;
      ret.valid     = 1'b1;
      ret.ret_type  = (kind == 2) ? IFILL_RET : (kind == 3) ? ST_ACK : LOAD_RET;
      ret.noncache  = pkt.noncache;
      ret.thread_id = pkt.thread_id;
      ret.info      = RETURN_INFO;
      if (kind != 3) ret.load_data = place_beat(ret.load_data, addr1);
      if (two_beat) ret.load_data = place_beat(ret.load_data, addr1 ^ 64'h8);
      exp_ret_q.push_back(ret);

      spc_req_i = region;   // Region first, packet one cycle later
      @(negedge sys_clock_i);
      spc_req_i       = '0;
      spc_packetout_i = pkt;
      @(negedge sys_clock_i);
      spc_packetout_i = '0;
      issued++;
   endtask

   // Timeout
   always @(posedge sys_clock_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == CYC_LIMIT) begin
         report_failure($sformatf("Timeout after %0d cycles, %0d of %0d returns seen",
                                  CYC_LIMIT, ret_count, NUM_REQ + 1));
      end
   end

   // Grant is the request two cycles back
   always @(posedge sys_clock_i) begin
      req_d1 <= spc_req_i;
      req_d2 <= req_d1;
   end

   always @(negedge sys_clock_i) begin
      check_value("spc_grant_o", spc_grant_o, req_d2);
   end

   // Wishbone slave with random ack delay
   always @(negedge sys_clock_i) begin
      if (!sys_reset_i) begin
         if (ack_active) begin
            wbm_ack_i  = 1'b0;
            wbm_data_i = '0;
            ack_active = 1'b0;
            check_value("wbm_cycle_o after ack", wbm_cycle_o, 1'b0);
            check_value("wbm_strobe_o after ack", wbm_strobe_o, 1'b0);
         end else if (wbm_strobe_o || in_access) begin
            if (!in_access) begin   // New access
               if (exp_addr_q.size() == 0) report_failure("Bus access with none expected");
               cur_addr  = exp_addr_q.pop_front();
               cur_sel   = exp_sel_q.pop_front();
               cur_we    = exp_we_q.pop_front();
               cur_wdata = exp_wdata_q.pop_front();
               in_access = 1'b1;
               wait_left = $unsigned($random(wb_seed)) % 6;
            end
            // Same compare holds the bus steady while waiting
            check_value("wbm_cycle_o during access", wbm_cycle_o, 1'b1);
            check_value("wbm_strobe_o during access", wbm_strobe_o, 1'b1);
            check_value("wbm_addr_o", wbm_addr_o, cur_addr);
            check_value("wbm_sel_o", wbm_sel_o, cur_sel);
            check_value("wbm_we_o", wbm_we_o, cur_we);
            check_value("wbm_data_o", wbm_data_o, cur_wdata);
            if (wait_left == 0) begin
               wbm_ack_i  = 1'b1;
               wbm_data_i = rd_data(cur_addr);   // Driven on writes too
               ack_active = 1'b1;
               in_access  = 1'b0;
            end else begin
               wait_left--;
            end
         end else begin
            check_value("wbm_cycle_o between accesses", wbm_cycle_o, 1'b0);
         end
      end
   end

   // Return monitor
   always @(negedge sys_clock_i) begin
      if (!sys_reset_i) begin
         if (spc_ready_o) begin
            if (prev_ready) report_failure("spc_ready_o was high on two cycles in a row");
            if (exp_ret_q.size() == 0) report_failure("Return packet with none expected");
            check_value("spc_packetin_o", spc_packetin_o, exp_ret_q.pop_front());
            ret_count <= ret_count + 1;   // Seen by the driver on the next edge
         end else begin
            check_value("spc_packetin_o between pulses", spc_packetin_o, '0);
         end
         prev_ready = spc_ready_o;
      end
   end

   initial begin
      cpx_packet_t wakeup;
      sys_reset_i     = 1'b1;
      spc_req_i       = '0;
      spc_packetout_i = '0;
      wbm_ack_i       = 1'b0;
      wbm_data_i      = '0;

      wakeup           = '0;   // First return after reset
      wakeup.valid     = 1'b1;
      wakeup.ret_type  = INT_RET;
      wakeup.load_data = WAKEUP_DATA;
      exp_ret_q.push_back(wakeup);

      repeat (10) @(negedge sys_clock_i);
      check_value("wbm_cycle_o in reset", wbm_cycle_o, 1'b0);
      check_value("wbm_strobe_o in reset", wbm_strobe_o, 1'b0);
      check_value("wbm_we_o in reset", wbm_we_o, 1'b0);
      check_value("wbm_addr_o in reset", wbm_addr_o, '0);
      check_value("wbm_data_o in reset", wbm_data_o, '0);
      check_value("wbm_sel_o in reset", wbm_sel_o, '0);
      check_value("spc_ready_o in reset", spc_ready_o, 1'b0);
      check_value("spc_packetin_o in reset", spc_packetin_o, '0);
      sys_reset_i = 1'b0;

      while (issued < NUM_REQ) begin
         // At most two requests in flight
         while ((issued + 1 - ret_count) >= 2) @(negedge sys_clock_i);
         send_request();
      end
      while (ret_count < NUM_REQ + 1) @(negedge sys_clock_i);
      repeat (20) @(negedge sys_clock_i);   // Catch stray returns or accesses

      if ((exp_ret_q.size() == 0) && (exp_addr_q.size() == 0)) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         report_failure("Expected returns or bus accesses never arrived");
      end
   end

endmodule

`default_nettype wire

/* files.f */
common/bridge_pkg.sv
common/pkt_fifo_if.sv
logic/pkt_fifo.sv
logic/pcx_capture.sv
wb_master/wb_request_engine.sv
logic/cpx_return_stage.sv
logic/spc2wb_bridge.sv
verif/tb_spc2wb_bridge.sv

/* Bender.yml */
package:
  name: spc2wb_bridge

sources:
  - files:
      - common/bridge_pkg.sv
      - common/pkt_fifo_if.sv
      - logic/pkt_fifo.sv
      - logic/pcx_capture.sv
      - wb_master/wb_request_engine.sv
      - logic/cpx_return_stage.sv
      - logic/spc2wb_bridge.sv
  - target: test
    files:
      - verif/tb_spc2wb_bridge.sv
